//--- verilog/status_gen_config.svh
// Constants for the byte-serial status message generator.
// Include wherever a width, a byte count or the status address is needed.
// The message is the address byte followed by three payload bytes.

`ifndef STATUS_GEN_CONFIG_SVH
`define STATUS_GEN_CONFIG_SVH

// address byte sent first in every message
`define STATUS_REG_ADDR 8'd7

`define BYTE_BITS       8    // width of the ad port
`define PAYLOAD_BITS    15   // status word width
`define SEQ_BITS        6    // sequence number width
`define MODE_BITS       2    // mode field of the command byte

`define MSG_BYTES       4    // address plus payload
`define PAYLOAD_BYTES   3    // bytes after the address

// counter wide enough to pace the payload bytes
`define BYTE_CNT_BITS   2

`endif

//--- verilog/status_gen_pkg.sv
// Shared types for the status message generator.
// Modules name these types in their ports as status_gen_pkg::<type>
// and import the package inside the body when they need more.

`include "status_gen_config.svh"

package status_gen_pkg;

    // command mode, upper two bits of the command byte
    typedef enum logic [`MODE_BITS-1:0] {
        mode_off       = 2'd0, // no messages
        mode_single    = 2'd1, // one message per write
        mode_auto_keep = 2'd2, // resend on change, fixed seq
        mode_auto_inc  = 2'd3  // resend on change, seq + 1 each message
    } gen_mode_e;

    // request / payload sequencer states
    typedef enum logic [1:0] {
        st_idle    = 2'd0, // nothing to send
        st_request = 2'd1, // rq high, waiting for start
        st_payload = 2'd2  // bytes 1..3 going out
    } seq_state_e;

    // frame taken at start, 21 bits
    typedef struct packed {
        logic [`SEQ_BITS-1:0]     seq;    // sequence number for byte 1
        logic [`PAYLOAD_BITS-1:0] status; // registered status word
    } status_frame_t;

    // overlay of the 8-bit command byte
    typedef struct packed {
        gen_mode_e            mode; // bits 7:6
        logic [`SEQ_BITS-1:0] seq;  // bits 5:0
    } gen_cmd_t;

endpackage

//--- verilog/status_tracker.sv
// Producer side of the status generator.
// Decodes host commands, keeps mode and sequence number, registers the
// status word and flags when a message is due. The frame output holds
// the current seq and registered status, latched downstream at start.

`include "status_gen_config.svh"

module status_tracker (
    input  logic                          rst,       // clock
    input  logic                          clk,       // async reset, active high
    input  logic                          srst,      // sync reset
    input  logic                          we,        // command strobe
    input  status_gen_pkg::gen_cmd_t      wd,        // command byte
    input  logic [`PAYLOAD_BITS-1:0]      status,    // may be from another domain
    input  logic                          start,     // message taken downstream
    output logic                          need_send, // level, a message is due
    output status_gen_pkg::status_frame_t frame      // seq + registered status
);
    import status_gen_pkg::*;

    gen_mode_e                mode;           // current mode
    logic [`SEQ_BITS-1:0]     seq;            // current sequence number
    logic                     cmd_pend;       // write with nonzero mode not yet sent
    logic [`PAYLOAD_BITS-1:0] status_r0;      // status after one register stage
    logic [`PAYLOAD_BITS-1:0] status_sent;    // status carried by the last message
    logic                     status_changed; // sticky until next start
    logic                     auto_mode;      // one of the two automatic modes

    assign auto_mode = (mode == mode_auto_keep) || (mode == mode_auto_inc);

    // combinational so a pending command reaches rq on the next clock
    assign need_send = cmd_pend || (auto_mode && status_changed);

    assign frame.seq    = seq;       // old seq goes out, increment lands with start
    assign frame.status = status_r0; // status one cycle before start

    // mode and sequence number
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mode <= mode_off;
            seq  <= '0;
        end else if (srst) begin
            mode <= mode_off;
            seq  <= '0;
        end else if (we) begin
            mode <= wd.mode;                 // upper two bits
            seq  <= wd.seq;                  // lower six bits
        end else if (start && (mode == mode_auto_inc)) begin
            seq  <= seq + 1'b1;              // wraps at 64
        end
    end

    // pending command flag
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cmd_pend <= 1'b0;
        end else if (srst) begin
            cmd_pend <= 1'b0;
        end else if (we && (wd.mode != mode_off)) begin
            cmd_pend <= 1'b1;                // any mode but off asks for a message
        end else if (start) begin
            cmd_pend <= 1'b0;                // served
        end
    end

    // input register for the status word
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_r0 <= '0;
        end else if (srst) begin
            status_r0 <= '0;
        end else begin
            status_r0 <= status;             // single stage, always registered
        end
    end

    // last-sent copy, compared against the live registered status
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_sent <= '0;
        end else if (srst) begin
            status_sent <= '0;
        end else if (start) begin
            status_sent <= status_r0;        // same value the frame carries
        end
    end

    // change flag, stays set even if status returns to the sent value
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_changed <= 1'b0;
        end else if (srst) begin
            status_changed <= 1'b0;
        end else if (start) begin
            status_changed <= 1'b0;
        end else begin
            status_changed <= status_changed || (status_sent != status_r0);
        end
    end

endmodule

//--- verilog/packet_shifter.sv
// Output byte buffer of the status generator.
// Loads the payload at start and moves it out one byte per shift pulse.
// Whenever no payload byte is due the address byte is presented on ad.

`include "status_gen_config.svh"

module packet_shifter (
    input  logic                          rst,   // clock
    input  logic                          clk,   // async reset, active high
    input  logic                          srst,  // sync reset
    input  logic                          start, // load the frame
    input  logic                          shift, // advance by one byte
    input  status_gen_pkg::status_frame_t frame, // seq + status at start
    output logic [`BYTE_BITS-1:0]         ad     // address / data byte
);
    // payload bytes 1..3
    localparam int DATA_BITS = (`MSG_BYTES - 1) * `BYTE_BITS;
    // zero fill above status bit 14 in byte 3
    localparam int PAD_BITS  = DATA_BITS - `SEQ_BITS - `PAYLOAD_BITS;

    localparam logic [DATA_BITS-1:0] ADDR_WORD = DATA_BITS'(`STATUS_REG_ADDR);

    logic [DATA_BITS-1:0] data;       // byte 1 in the low byte
    logic [DATA_BITS-1:0] frame_word; // frame laid out as bytes 3..1

    // byte 1: seq, status[1:0]; byte 2: status[9:2]; byte 3: pad, status[14:10]
    assign frame_word = {
        {PAD_BITS{1'b0}},
        frame.status[`PAYLOAD_BITS-1:2],
        frame.seq,
        frame.status[1:0]
    };

    assign ad = data[`BYTE_BITS-1:0];

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            data <= ADDR_WORD;
        end else if (srst) begin
            data <= ADDR_WORD;               // abandon a message in flight
        end else if (start) begin
            data <= frame_word;              // byte 1 shows on the next cycle
        end else if (shift) begin
            data <= data >> `BYTE_BITS;      // bytes 2 and 3
        end else begin
            data <= ADDR_WORD;               // back to the address after byte 3
        end
    end

endmodule

//--- verilog/rq_sequencer.sv
// Request and payload pacing for the status generator.
// Raises rq when a message is due, and after the start pulse counts the
// three payload cycles, driving shift on the first two. rq drops on the
// last payload byte to mark the end of the message.

`include "status_gen_config.svh"

module rq_sequencer (
    input  logic rst,       // clock
    input  logic clk,       // async reset, active high
    input  logic srst,      // sync reset
    input  logic need_send, // from the tracker
    input  logic start,     // downstream took the address byte
    output logic rq,        // level request to downstream
    output logic shift      // advance the byte buffer
);
    import status_gen_pkg::*;

    localparam logic [`BYTE_CNT_BITS-1:0] LAST_CNT = `BYTE_CNT_BITS'(`PAYLOAD_BYTES - 1);

    seq_state_e                state;
    logic [`BYTE_CNT_BITS-1:0] byte_cnt;  // payload byte index, 0 is byte 1
    logic                      in_payload;
    logic                      last_byte; // byte 3 on ad

    assign in_payload = (state == st_payload);
    assign last_byte  = in_payload && (byte_cnt == LAST_CNT);

    // rq low on the last byte is the end marker downstream sees
    assign rq    = (state == st_request) || (in_payload && !last_byte);
    assign shift = in_payload && !last_byte;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state    <= st_idle;
            byte_cnt <= '0;
        end else if (srst) begin
            state    <= st_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (need_send) begin
                        state <= st_request;     // rq on the next clock
                    end
                end
                st_request: begin
                    if (start) begin
                        state    <= st_payload;  // waits here as long as needed
                        byte_cnt <= '0;
                    end
                end
                st_payload: begin
                    if (last_byte) begin
                        // a queued message may request right after byte 3
                        state    <= need_send ? st_request : st_idle;
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: begin
                    state    <= st_idle;
                    byte_cnt <= '0;
                end
            endcase
        end
    end

endmodule

//--- verilog/status_generate.sv
// Top level of the byte-serial status message generator.
// A host writes mode and seq through we/wd, status is sampled every clock,
// and a message is offered downstream on rq/start with bytes on ad.
// Message: address 7, then {seq, status[1:0]}, status[9:2], status[14:10].

`include "status_gen_config.svh"

module status_generate (
    input  logic                     rst,    // clock
    input  logic                     clk,    // async reset, active high
    input  logic                     srst,   // sync reset
    input  logic                     we,     // command strobe, one cycle
    input  status_gen_pkg::gen_cmd_t wd,     // mode and seq
    input  logic [`PAYLOAD_BITS-1:0] status, // parallel status word
    output logic [`BYTE_BITS-1:0]    ad,     // address / data byte
    output logic                     rq,     // request, low on last byte
    input  logic                     start   // acknowledge of the address byte
);
    import status_gen_pkg::*;

    logic          need_send; // tracker to sequencer
    logic          shift;     // sequencer to shifter
    status_frame_t frame;     // tracker to shifter

    status_tracker u_tracker (
        .rst       (rst),
        .clk       (clk),
        .srst      (srst),
        .we        (we),
        .wd        (wd),
        .status    (status),
        .start     (start),
        .need_send (need_send),
        .frame     (frame)
    );

    packet_shifter u_shifter (
        .rst   (rst),
        .clk   (clk),
        .srst  (srst),
        .start (start),
        .shift (shift),
        .frame (frame),
        .ad    (ad)
    );

    rq_sequencer u_sequencer (
        .rst       (rst),
        .clk       (clk),
        .srst      (srst),
        .need_send (need_send),
        .start     (start),
        .rq        (rq),
        .shift     (shift)
    );

endmodule

//--- tb/status_generate_assert.sv
// Bound checker for the status message generator.
// Keeps a small model of mode, seq and pending command, and checks the
// idle address, message framing, single and automatic requests with
// concurrent assertions. fail_cnt is read by the testbench.

`include "status_gen_config.svh"

module status_generate_assert (
    input logic                     rst,    // clock
    input logic                     clk,    // async reset, active high
    input logic                     srst,   // sync reset
    input logic                     we,
    input status_gen_pkg::gen_cmd_t wd,
    input logic [`PAYLOAD_BITS-1:0] status,
    input logic [`BYTE_BITS-1:0]    ad,
    input logic                     rq,
    input logic                     start
);
    timeunit 1ns;
    timeprecision 1ps;
    import status_gen_pkg::*;

    int                       fail_cnt = 0; // failed assertions so far
    gen_mode_e                m_mode;       // model mode
    logic [`SEQ_BITS-1:0]     m_seq;        // model seq
    logic                     m_pend;       // model pending command
    logic [`PAYLOAD_BITS-1:0] status_q;     // status one clock back
    logic [1:0]               left;         // payload bytes still due
    logic [`BYTE_BITS-1:0]    exp_b1;
    logic [`BYTE_BITS-1:0]    exp_b2;
    logic [`BYTE_BITS-1:0]    exp_b3;
    int                       quiet;        // idle cycles with stable status
    logic                     auto_m;

    assign auto_m = (m_mode == mode_auto_keep) || (m_mode == mode_auto_inc);

    always_ff @(posedge rst or posedge clk) begin
        if (clk || srst) begin
            m_mode   <= mode_off;
            m_seq    <= '0;
            m_pend   <= 1'b0;
            status_q <= '0;
            left     <= 2'd0;
            exp_b1   <= '0;
            exp_b2   <= '0;
            exp_b3   <= '0;
            quiet    <= 0;
        end else begin
            status_q <= status;
            if (we) begin
                m_mode <= wd.mode;
                m_seq  <= wd.seq;
            end else if (start && (m_mode == mode_auto_inc)) begin
                m_seq  <= m_seq + 6'd1;          // modulo 64
            end
            if (we && (wd.mode != mode_off)) begin
                m_pend <= 1'b1;
            end else if (start) begin
                m_pend <= 1'b0;
            end
            if (start) begin
                left   <= 2'd3;
                exp_b1 <= {m_seq, status_q[1:0]};  // status one cycle before start
                exp_b2 <= status_q[9:2];
                exp_b3 <= {3'b000, status_q[14:10]};
            end else if (left != 2'd0) begin
                left   <= left - 2'd1;
            end
            if (!rq && (left == 2'd0) && !we && (status == status_q) && auto_m) begin
                quiet <= (quiet < 8) ? quiet + 1 : quiet;
            end else begin
                quiet <= 0;
            end
        end
    end

    // downstream only acknowledges an open request
    start_legal: assume property (@(posedge rst) disable iff (clk || srst)
        start |-> rq && (left == 2'd0))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("start without open request");
        end

    idle_addr: assert property (@(posedge rst) disable iff (clk || srst)
        (!rq && (left == 2'd0)) |-> (ad == `STATUS_REG_ADDR))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ad not address while idle");
        end

    msg_frame: assert property (@(posedge rst) disable iff (clk || srst)
        start |=> (rq && (ad == exp_b1)) ##1 (rq && (ad == exp_b2))
                  ##1 (!rq && (ad == exp_b3)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("payload bytes or rq wrong");
        end

    // pending flag lands with the strobe, rq follows one clock later
    single_rq: assert property (@(posedge rst) disable iff (clk || srst)
        (we && (wd.mode == mode_single) && (left == 2'd0) && !start) |=> ##1 rq)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("single write did not raise rq");
        end

    no_spurious: assert property (@(posedge rst) disable iff (clk || srst)
        (!m_pend && !auto_m && !rq && (left == 2'd0)) |=> !rq)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rq raised with nothing to send");
        end

    auto_latency: assert property (@(posedge rst) disable iff (clk || srst)
        (auto_m && (quiet >= 3) && !rq && (left == 2'd0) && !we && (status != status_q))
        |=> !rq ##1 !rq ##1 rq)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("auto rq not three clocks after change");
        end

endmodule

//--- tb/status_generate_tb.sv
// Testbench for the status message generator.
// Drives commands, status changes and downstream start pulses through
// every mode; the bound checker does the checking.

`include "status_gen_config.svh"

module status_generate_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import status_gen_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int SINGLE_RUNS    = 6;
    localparam int OFF_RUNS       = 4;
    localparam int KEEP_RUNS      = 6;
    localparam int INC_RUNS       = 8;
    localparam int MAX_MSG_CYCLES = 32; // longest iteration of any phase
    localparam int TOTAL_RUNS     = SINGLE_RUNS + OFF_RUNS + KEEP_RUNS + INC_RUNS + 4;
    localparam int TIMEOUT_NS     = (RESET_CYCLES + TOTAL_RUNS * MAX_MSG_CYCLES) * CLK_PERIOD;

    logic                     rst;    // clock
    logic                     clk;    // async reset
    logic                     srst;
    logic                     we;
    gen_cmd_t                 wd;
    logic [`PAYLOAD_BITS-1:0] status;
    logic [`BYTE_BITS-1:0]    ad;
    logic                     rq;
    logic                     start;

    status_generate uut (
        .rst    (rst),
        .clk    (clk),
        .srst   (srst),
        .we     (we),
        .wd     (wd),
        .status (status),
        .ad     (ad),
        .rq     (rq),
        .start  (start)
    );

    bind status_generate status_generate_assert u_chk (
        .rst(rst), .clk(clk), .srst(srst), .we(we), .wd(wd),
        .status(status), .ad(ad), .rq(rq), .start(start)
    );

    initial rst = 1'b0;
    always #(CLK_PERIOD / 2) rst = ~rst;

    task automatic idle(input int n);
        repeat (n) @(negedge rst);
    endtask

    task automatic write_cmd(input gen_mode_e m, input logic [`SEQ_BITS-1:0] s);
        we      = 1'b1;
        wd.mode = m;
        wd.seq  = s;
        @(negedge rst);
        we      = 1'b0;
    endtask

    // wait for rq, acknowledge after a delay, let the payload pass
    task automatic serve_message(input int delay);
        while (rq !== 1'b1) @(negedge rst);
        idle(delay);
        start = 1'b1;
        @(negedge rst);
        start = 1'b0;
        idle(3);
    endtask

    task automatic new_status();
        logic [`PAYLOAD_BITS-1:0] nxt;
        nxt = 15'($urandom);
        while (nxt == status) nxt = 15'($urandom);
        status = nxt;
    endtask

    // first failed assertion ends the run
    always @(negedge rst) begin
        if (uut.u_chk.fail_cnt != 0) begin
            $display("** Error at %0t ns: concurrent assertion failed", $time);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first assertion failure");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'h15e5ddad));
        clk    = 1'b1;
        srst   = 1'b0;
        we     = 1'b0;
        wd     = '0;
        status = '0;
        start  = 1'b0;
        idle(RESET_CYCLES);
        clk = 1'b0;
        idle(4);

        for (int i = 0; i < SINGLE_RUNS; i++) begin    // single requests
            write_cmd(mode_single, 6'($urandom));
            serve_message(int'($urandom_range(5, 0)));
            idle(4);
            new_status();                               // must not resend
            idle(6);
        end

        write_cmd(mode_off, 6'd0);
        for (int i = 0; i < OFF_RUNS; i++) begin
            idle(5);
            new_status();
            idle(6);
        end

        write_cmd(mode_auto_keep, 6'($urandom));
        serve_message(int'($urandom_range(5, 0)));
        for (int i = 0; i < KEEP_RUNS; i++) begin
            idle(5);
            new_status();
            serve_message(int'($urandom_range(5, 0)));
        end

        write_cmd(mode_auto_inc, 6'd61);                // crosses the wrap at 64
        serve_message(int'($urandom_range(5, 0)));
        for (int i = 0; i < INC_RUNS; i++) begin
            idle(5);
            new_status();
            serve_message(int'($urandom_range(5, 0)));
        end

        write_cmd(mode_single, 6'd5);                   // srst in mid-message
        while (rq !== 1'b1) @(negedge rst);
        start = 1'b1;
        @(negedge rst);
        start = 1'b0;
        srst  = 1'b1;
        @(negedge rst);
        srst  = 1'b0;
        idle(6);

        if (uut.u_chk.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures counted at end of run");
        end
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/status_gen_pkg.sv
verilog/status_tracker.sv
verilog/packet_shifter.sv
verilog/rq_sequencer.sv
verilog/status_generate.sv
tb/status_generate_assert.sv
tb/status_generate_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = status_generate_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
